// ==== source/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Integer register and datapath width (RV32)
    localparam int xlen = 32;

    // ADDI x0, x0, 0
    localparam logic [31:0] instr_nop = 32'h0000_0013;

    // Writeback result source, chosen by decode
    typedef enum logic [2:0] {
        res_alu       = 3'd0,
        res_mem       = 3'd1,
        res_pc_plus4  = 3'd2,
        res_jb_target = 3'd3,
        res_csr       = 3'd4
    } res_src_e;

    // Load and store widths, encoded as the funct3 field
    // Stores only use the signed encodings
    typedef enum logic [2:0] {
        mem_b  = 3'b000,
        mem_h  = 3'b001,
        mem_w  = 3'b010,
        mem_bu = 3'b100,
        mem_hu = 3'b101
    } mem_width_e;

endpackage

// ==== source/rv_stage_pkg.sv ====
package rv_stage_pkg;

    import rv_isa_pkg::*;

    // Bundle handed from EX to MEM
    typedef struct packed {
        logic             reg_write;
        logic             mem_write;
        res_src_e         res_src;
        logic [2:0]       funct3;
        logic [31:0]      instr;
        logic [4:0]       rd;
        // Also the data memory byte address
        logic [xlen-1:0]  alu_result;
        logic [xlen-1:0]  store_data;
        logic [xlen-1:0]  pc_plus4;
        logic [xlen-1:0]  jb_target;
        logic [xlen-1:0]  csr_rdata;
    } ex_mem_t;

    // Bundle handed from MEM to WB
    typedef struct packed {
        logic             reg_write;
        res_src_e         res_src;
        logic [2:0]       funct3;
        logic [31:0]      instr;
        logic [4:0]       rd;
        logic [xlen-1:0]  alu_result;
        // Load data already extended to xlen
        logic [xlen-1:0]  dmem_rdata_ext;
        logic [xlen-1:0]  pc_plus4;
        logic [xlen-1:0]  jb_target;
        logic [xlen-1:0]  csr_rdata;
    } mem_wb_t;

endpackage

// ==== source/rv_mem_stage.sv ====
module rv_mem_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_stage_pkg::ex_mem_t ex_mem,
    output rv_stage_pkg::mem_wb_t mem
);

    import rv_isa_pkg::*;

    localparam int nbytes      = xlen / 8;
    localparam int word_addr_w = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    // DMEM_WORDS is expected to be a power of two, so the slice wraps the address
    logic [xlen-1:0]        dmem [DMEM_WORDS];

    mem_width_e             width;
    logic [1:0]             byte_off;
    logic [word_addr_w-1:0] word_idx;
    logic [nbytes-1:0]      byte_en;
    logic [xlen-1:0]        wdata;
    logic [xlen-1:0]        rword;
    logic [7:0]             rbyte;
    logic [15:0]            rhalf;
    logic [xlen-1:0]        rdata_ext;

    assign width    = mem_width_e'(ex_mem.funct3);
    assign byte_off = ex_mem.alu_result[1:0];
    assign word_idx = ex_mem.alu_result[word_addr_w+1:2];

    // Store lanes and replicated store data
    always_comb begin
        byte_en = '0;
        wdata   = ex_mem.store_data;
        case (width)
            mem_b, mem_bu: begin
                byte_en = 4'b0001 << byte_off;
                wdata   = {4{ex_mem.store_data[7:0]}};
            end
            mem_h, mem_hu: begin
                byte_en = 4'b0011 << {byte_off[1], 1'b0};
                wdata   = {2{ex_mem.store_data[15:0]}};
            end
            default: begin
                byte_en = '1;
            end
        endcase
    end

    // Memory is left alone while reset is held
    always_ff @(posedge clk) begin
        if (rst_n && ex_mem.mem_write) begin
            for (int i = 0; i < nbytes; i++) begin
                if (byte_en[i]) begin
                    dmem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // Load path, combinational in the same cycle
    assign rword = dmem[word_idx];
    assign rbyte = rword[8*byte_off +: 8];
    assign rhalf = rword[16*byte_off[1] +: 16];

    always_comb begin
        case (width)
            mem_b:   rdata_ext = {{(xlen-8){rbyte[7]}}, rbyte};
            mem_h:   rdata_ext = {{(xlen-16){rhalf[15]}}, rhalf};
            mem_bu:  rdata_ext = {{(xlen-8){1'b0}}, rbyte};
            mem_hu:  rdata_ext = {{(xlen-16){1'b0}}, rhalf};
            default: rdata_ext = rword;
        endcase
    end

    // Everything else moves on unchanged
    always_comb begin
        mem.reg_write      = ex_mem.reg_write;
        mem.res_src        = ex_mem.res_src;
        mem.funct3         = ex_mem.funct3;
        mem.instr          = ex_mem.instr;
        mem.rd             = ex_mem.rd;
        mem.alu_result     = ex_mem.alu_result;
        mem.dmem_rdata_ext = rdata_ext;
        mem.pc_plus4       = ex_mem.pc_plus4;
        mem.jb_target      = ex_mem.jb_target;
        mem.csr_rdata      = ex_mem.csr_rdata;
    end

endmodule

// ==== source/rv_reg_mem_wb.sv ====
module rv_reg_mem_wb #(
    parameter int PIPELINED = 1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_stage_pkg::mem_wb_t mem,
    output rv_stage_pkg::mem_wb_t wb
);

    import rv_isa_pkg::*;

    if (PIPELINED != 0) begin : g_registered
        always_ff @(posedge clk) begin
            // Payload fields carry no reset
            wb.res_src        <= mem.res_src;
            wb.rd             <= mem.rd;
            wb.alu_result     <= mem.alu_result;
            wb.dmem_rdata_ext <= mem.dmem_rdata_ext;
            wb.pc_plus4       <= mem.pc_plus4;
            wb.jb_target      <= mem.jb_target;
            wb.csr_rdata      <= mem.csr_rdata;

            // Control state, instr comes out of reset as a NOP
            if (!rst_n) begin
                wb.reg_write <= 1'b0;
                wb.funct3    <= '0;
                wb.instr     <= instr_nop;
            end else begin
                wb.reg_write <= mem.reg_write;
                wb.funct3    <= mem.funct3;
                wb.instr     <= mem.instr;
            end
        end
    end else begin : g_passthrough
        // No stage here, MEM and WB share one cycle
        assign wb = mem;
    end

endmodule

// ==== source/rv_writeback.sv ====
module rv_writeback (
    input  rv_stage_pkg::mem_wb_t       wb,
    output logic                        wr_en,
    output logic [4:0]                  wr_addr,
    output logic [rv_isa_pkg::xlen-1:0] wr_data
);

    import rv_isa_pkg::*;

    // The register file drops writes to x0 itself
    assign wr_en   = wb.reg_write;
    assign wr_addr = wb.rd;

    // Result mux
    always_comb begin
        case (wb.res_src)
            res_alu: begin
                wr_data = wb.alu_result;
            end
            res_mem: begin
                wr_data = wb.dmem_rdata_ext;
            end
            // Link address for JAL and JALR
            res_pc_plus4: begin
                wr_data = wb.pc_plus4;
            end
            // auipc style result, target computed in EX
            res_jb_target: begin
                wr_data = wb.jb_target;
            end
            res_csr: begin
                wr_data = wb.csr_rdata;
            end
            default: begin
                wr_data = wb.alu_result;
            end
        endcase
    end

endmodule

// ==== source/rv_regfile.sv ====
module rv_regfile (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        wr_en,
    input  logic [4:0]                  wr_addr,
    input  logic [rv_isa_pkg::xlen-1:0] wr_data,
    input  logic [4:0]                  rs1_addr,
    input  logic [4:0]                  rs2_addr,
    output logic [rv_isa_pkg::xlen-1:0] rs1_data,
    output logic [rv_isa_pkg::xlen-1:0] rs2_data
);

    import rv_isa_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Read ports see the old value during a write, no bypass
    always_comb begin
        if (rs1_addr == 5'd0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1_addr];
        end
    end

    always_comb begin
        if (rs2_addr == 5'd0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

// ==== source/rv_mem_wb_top.sv ====
module rv_mem_wb_top #(
    parameter int PIPELINED  = 1,
    parameter int DMEM_WORDS = 256
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  rv_stage_pkg::ex_mem_t       ex_mem,
    input  logic [4:0]                  rs1_addr,
    input  logic [4:0]                  rs2_addr,
    output logic [rv_isa_pkg::xlen-1:0] rs1_data,
    output logic [rv_isa_pkg::xlen-1:0] rs2_data,
    // Retire port, mirrors the register file write
    output logic                        wb_write,
    output logic [4:0]                  wb_rd,
    output logic [rv_isa_pkg::xlen-1:0] wb_data,
    output logic [31:0]                 wb_instr
);

    import rv_stage_pkg::*;

    mem_wb_t mem;
    mem_wb_t wb;

    rv_mem_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) mem_stage0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_mem (ex_mem),
        .mem    (mem)
    );

    rv_reg_mem_wb #(
        .PIPELINED (PIPELINED)
    ) reg_mem_wb0 (
        .clk   (clk),
        .rst_n (rst_n),
        .mem   (mem),
        .wb    (wb)
    );

    rv_writeback writeback0 (
        .wb      (wb),
        .wr_en   (wb_write),
        .wr_addr (wb_rd),
        .wr_data (wb_data)
    );

    rv_regfile regfile0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wb_write),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign wb_instr = wb.instr;

endmodule

// ==== testbench/rv_mem_wb_properties.sv ====
module rv_mem_wb_properties #(
    parameter int PIPELINED = 1
) (
    input logic                        clk,
    input logic                        rst_n,
    input rv_stage_pkg::ex_mem_t       ex_mem,
    input logic [4:0]                  rs1_addr,
    input logic [rv_isa_pkg::xlen-1:0] rs1_data,
    input logic                        wb_write,
    input logic [31:0]                 wb_instr
);

    timeunit 1ns;
    timeprecision 100ps;

    import rv_isa_pkg::*;

    int violations = 0;

    // x0 reads zero on the observation port
    a_x0_zero: assert property (@(posedge clk) rs1_addr == 5'd0 |-> rs1_data == '0)
        else begin
            $error("rs1 read port returned nonzero data for x0");
            violations++;
        end

    if (PIPELINED != 0) begin : g_registered
        // Retire port idle with a NOP after every reset edge
        a_reset_idle: assert property (@(posedge clk)
            !rst_n |=> (!wb_write && wb_instr == instr_nop))
            else begin
                $error("retire port not idle after reset");
                violations++;
            end

        // One cycle from EX/MEM to the retire port
        a_write_follows: assert property (@(posedge clk) disable iff (!rst_n)
            ex_mem.reg_write |=> wb_write)
            else begin
                $error("register write did not retire one cycle later");
                violations++;
            end

        a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
            !ex_mem.reg_write |=> !wb_write)
            else begin
                $error("retire port wrote without a writing instruction");
                violations++;
            end
    end

endmodule

bind rv_mem_wb_top rv_mem_wb_properties #(
    .PIPELINED (PIPELINED)
) props0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .ex_mem   (ex_mem),
    .rs1_addr (rs1_addr),
    .rs1_data (rs1_data),
    .wb_write (wb_write),
    .wb_instr (wb_instr)
);

// ==== testbench/rv_mem_wb_tb.sv ====
module rv_mem_wb_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rv_isa_pkg::*;
    import rv_stage_pkg::*;

    localparam int clk_period = 100;
    localparam int dmem_words = 256;
    // Reset, alu, load/store, sources, back-to-back, reset test, margin
    localparam int budget_cycles = 10 + 100 + 220 + 50 + 60 + 50 + 100;

    logic            clk;
    logic            rst_n;
    ex_mem_t         ex_mem;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            wb_write;
    logic [4:0]      wb_rd;
    logic [xlen-1:0] wb_data;
    logic [31:0]     wb_instr;

    int seed = 32'h7d868e98;
    int errors = 0;
    int passed = 0;
    int failed = 0;

    // Reference model state
    logic [xlen-1:0] ref_regs [32];
    logic [xlen-1:0] ref_mem [dmem_words];

    mem_width_e store_widths [3] = '{mem_b, mem_h, mem_w};
    mem_width_e load_widths [5] = '{mem_b, mem_h, mem_w, mem_bu, mem_hu};
    res_src_e   wb_sources [4] = '{res_alu, res_pc_plus4, res_jb_target, res_csr};

    rv_mem_wb_top #(
        .PIPELINED  (1),
        .DMEM_WORDS (dmem_words)
    ) dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_mem   (ex_mem),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_write (wb_write),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .wb_instr (wb_instr)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic ex_mem_t idle_op();
        ex_mem_t op;
        op = '0;
        op.instr = instr_nop;
        return op;
    endfunction

    // Random payload in every field so a wrong select shows up
    task automatic random_op(output ex_mem_t op);
        op = idle_op();
        op.instr      = $random(seed);
        op.alu_result = $random(seed);
        op.store_data = $random(seed);
        op.pc_plus4   = $random(seed);
        op.jb_target  = $random(seed);
        op.csr_rdata  = $random(seed);
    endtask

    task automatic pick_rd(output logic [4:0] rd);
        rd = 5'($random(seed));
        if (rd == 5'd0) begin
            rd = 5'd1;
        end
    endtask

    // Aligned byte offset for the access width
    task automatic pick_lane(input mem_width_e w, output logic [1:0] off);
        off = 2'($random(seed));
        case (w)
            mem_h, mem_hu: off[0] = 1'b0;
            mem_w:         off = 2'b00;
            default:       ;
        endcase
    endtask

    function automatic logic [xlen-1:0] load_value(logic [xlen-1:0] word, logic [2:0] f3,
                                                   logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * off));
        h = off[1] ? word[31:16] : word[15:0];
        case (mem_width_e'(f3))
            mem_b:   return {{24{b[7]}}, b};
            mem_h:   return {{16{h[15]}}, h};
            mem_bu:  return {24'd0, b};
            mem_hu:  return {16'd0, h};
            default: return word;
        endcase
    endfunction

    function automatic logic [xlen-1:0] expected_result(ex_mem_t op);
        case (op.res_src)
            res_mem:       return load_value(ref_mem[op.alu_result[9:2]], op.funct3,
                                             op.alu_result[1:0]);
            res_pc_plus4:  return op.pc_plus4;
            res_jb_target: return op.jb_target;
            res_csr:       return op.csr_rdata;
            default:       return op.alu_result;
        endcase
    endfunction

    // Merge store data into the model word by lane mask
    task automatic model_store(ex_mem_t op);
        logic [7:0]      idx;
        logic [xlen-1:0] mask;
        idx  = op.alu_result[9:2];
        case (mem_width_e'(op.funct3))
            mem_b:   mask = 32'h0000_00ff << (8 * op.alu_result[1:0]);
            mem_h:   mask = 32'h0000_ffff << (16 * op.alu_result[1]);
            default: mask = 32'hffff_ffff;
        endcase
        ref_mem[idx] = (ref_mem[idx] & ~mask) | ({4{op.store_data[7:0]}} & mask);
        if (mem_width_e'(op.funct3) == mem_h) begin
            ref_mem[idx] = (ref_mem[idx] & ~mask) | ({2{op.store_data[15:0]}} & mask);
        end else if (mem_width_e'(op.funct3) == mem_w) begin
            ref_mem[idx] = op.store_data;
        end
    endtask

    task automatic issue(input ex_mem_t op);
        @(negedge clk);
        ex_mem = op;
        if (op.reg_write && op.rd != 5'd0) begin
            ref_regs[op.rd] = expected_result(op);
        end
        if (op.mem_write) begin
            model_store(op);
        end
    endtask

    task automatic settle();
        @(negedge clk);
        ex_mem = idle_op();
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] exp,
                               input logic [xlen-1:0] act);
        assert (act === exp) else begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input logic [4:0] r);
        @(negedge clk);
        rs1_addr = r;
        rs2_addr = r;
        #(clk_period / 4);
        check_value(name, ref_regs[r], rs1_data);
        check_value(name, ref_regs[r], rs2_data);
    endtask

    // Retire port holds the instruction issued one cycle earlier
    task automatic check_retire(input string name, input ex_mem_t op);
        check_value({name, " wb_rd"}, {27'd0, op.rd}, {27'd0, wb_rd});
        check_value({name, " wb_data"}, expected_result(op), wb_data);
    endtask

    task automatic report_test(input string name, input int start);
        if (errors == start) begin
            passed++;
            $display("%s: ok", name);
        end else begin
            failed++;
            $display("%s: %0d mismatches", name, errors - start);
        end
    endtask

    task automatic alu_write_readback();
        ex_mem_t op;
        int      start;
        start = errors;
        for (int i = 0; i < 30; i++) begin
            random_op(op);
            op.reg_write = 1'b1;
            op.res_src   = res_alu;
            // Every fifth write aims at x0
            op.rd = (i % 5 == 0) ? 5'd0 : 5'($random(seed));
            issue(op);
            settle();
            check_retire("alu_writes", op);
            check_reg("alu_writes", op.rd);
        end
        report_test("alu_writes", start);
    endtask

    task automatic store_load_widths();
        ex_mem_t    op;
        logic [7:0] word;
        logic [1:0] off;
        logic [4:0] rd;
        int         start;
        start = errors;
        for (int s = 0; s < 3; s++) begin
            for (int n = 0; n < 4; n++) begin
                word = 8'($random(seed));
                // Full word first so every lane is known
                // Upper address bits wrap
                random_op(op);
                op.mem_write  = 1'b1;
                op.funct3     = mem_w;
                op.alu_result = {22'($random(seed)), word, 2'b00};
                issue(op);
                random_op(op);
                pick_lane(store_widths[2'(s)], off);
                op.mem_write  = 1'b1;
                op.funct3     = store_widths[2'(s)];
                op.alu_result = {22'($random(seed)), word, off};
                issue(op);
                for (int l = 0; l < 5; l++) begin
                    random_op(op);
                    pick_lane(load_widths[3'(l)], off);
                    pick_rd(rd);
                    op.reg_write  = 1'b1;
                    op.res_src    = res_mem;
                    op.rd         = rd;
                    op.funct3     = load_widths[3'(l)];
                    op.alu_result = {22'($random(seed)), word, off};
                    issue(op);
                    settle();
                    check_retire("load_store", op);
                    check_reg("load_store", rd);
                end
            end
        end
        report_test("load_store", start);
    endtask

    task automatic source_select();
        ex_mem_t    op;
        logic [4:0] rd;
        int         start;
        start = errors;
        for (int i = 0; i < 12; i++) begin
            random_op(op);
            pick_rd(rd);
            op.reg_write = 1'b1;
            op.rd        = rd;
            op.res_src   = wb_sources[2'(1 + i % 3)];
            issue(op);
            settle();
            check_retire("result_sources", op);
            check_reg("result_sources", rd);
        end
        report_test("result_sources", start);
    endtask

    task automatic back_to_back_writes();
        ex_mem_t op;
        int      start;
        start = errors;
        // Only four target registers so later writes overwrite earlier ones
        for (int i = 0; i < 20; i++) begin
            random_op(op);
            op.reg_write = 1'b1;
            op.rd        = 5'd8 + 5'($random(seed) & 3);
            op.res_src   = wb_sources[2'($random(seed))];
            issue(op);
        end
        settle();
        for (int r = 0; r < 32; r++) begin
            check_reg("back_to_back", 5'(r));
        end
        report_test("back_to_back", start);
    endtask

    task automatic reset_in_flight();
        ex_mem_t op;
        int      start;
        start = errors;
        // A write still in flight when reset arrives
        random_op(op);
        op.reg_write = 1'b1;
        op.rd        = 5'd3;
        issue(op);
        @(negedge clk);
        rst_n  = 1'b0;
        ex_mem = idle_op();
        @(posedge clk);
        #(clk_period / 4);
        check_value("reset", '0, {31'd0, wb_write});
        check_value("reset", instr_nop, wb_instr);
        @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        #(clk_period / 4);
        check_value("reset", '0, {31'd0, wb_write});
        check_value("reset", instr_nop, wb_instr);
        ref_regs = '{default: '0};
        for (int r = 0; r < 32; r++) begin
            check_reg("reset", 5'(r));
        end
        report_test("reset", start);
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        ex_mem   = idle_op();
        rs1_addr = 5'd0;
        rs2_addr = 5'd0;
        ref_regs = '{default: '0};
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        alu_write_readback();
        store_load_widths();
        source_select();
        back_to_back_writes();
        reset_in_flight();

        @(negedge clk);
        $display("%0d tests ok, %0d with errors, %0d property violations",
                 passed, failed, dut0.props0.violations);
        if (failed == 0 && dut0.props0.violations == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(budget_cycles * clk_period);
        $display("Timeout: the tests did not finish within %0d cycles", budget_cycles);
        $display("test failed");
        $finish;
    end

endmodule

// ==== sim.f ====
source/rv_isa_pkg.sv
source/rv_stage_pkg.sv
source/rv_mem_stage.sv
source/rv_reg_mem_wb.sv
source/rv_writeback.sv
source/rv_regfile.sv
source/rv_mem_wb_top.sv
testbench/rv_mem_wb_properties.sv
testbench/rv_mem_wb_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rv_mem_wb_tb -f sim.f -o rv_mem_wb_sim

# Result is judged from the log below, not from the exit code
./obj_dir/rv_mem_wb_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
